//--- filelist.f
rtl/histPkg.sv
rtl/hitCapture.sv
rtl/histRam.sv
rtl/histAccumulator.sv
rtl/peakFinder.sv
rtl/histTop.sv
tests/tbClock.sv
tests/histAccumulator_properties.sv
tests/histTb.sv

//--- Bender.yml
package:
  name: pixel_hist

sources:
  - rtl/histPkg.sv
  - rtl/hitCapture.sv
  - rtl/histRam.sv
  - rtl/histAccumulator.sv
  - rtl/peakFinder.sv
  - rtl/histTop.sv
  - target: test
    files:
      - tests/tbClock.sv
      - tests/histAccumulator_properties.sv
      - tests/histTb.sv

//--- tests/histTb.sv
`timescale 1ns/100ps

module histTb;

    localparam realtime clkPeriod     = 4.0;
    localparam int      binShift      = 6;
    localparam int      hitsPerFrame  = 200;
    localparam int      resCycles     = 8;
    localparam int      numFrames     = 5;
    localparam int      clearCycles   = 64;
    localparam int      numPixels     = 2 ** histPkg::PIXEL_BITS;
    localparam int      numBins       = 2 ** histPkg::BIN_BITS;
    localparam int      maxCount      = 2 ** histPkg::COUNT_BITS - 1;
    localparam int      timeoutCycles =
        2 * (resCycles + numFrames * (clearCycles + 2 * hitsPerFrame + 80));

    localparam int modeSparse  = 0;
    localparam int modeDense   = 1;
    localparam int modeSat     = 2;
    localparam int modeRestart = 3;
    localparam int modeDrop    = 4;

    logic           clk;
    logic           res;
    logic           start;
    logic           hitValid;
    histPkg::hit_t  hit;
    logic           busy;
    logic           accepting;
    logic           peakValid;
    histPkg::peak_t peak;
    logic           done;

    int             seed = 9;
    int             errors = 0;
    int             checks = 0;
    int             testsRun = 0;
    int             testsFailed = 0;
    int             peakIdx = 0;
    int             modelHits = 0;
    int             refHist [numPixels][numBins];  // reference histogram
    histPkg::peak_t seenPeak [numPixels];

    tbClock #(.period(clkPeriod)) i_tbClock (.clk(clk));

    histTop #(
        .binShift     (binShift),
        .hitsPerFrame (hitsPerFrame)
    ) i_histTop (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .hitValid  (hitValid),
        .hit       (hit),
        .busy      (busy),
        .accepting (accepting),
        .peakValid (peakValid),
        .peak      (peak),
        .done      (done)
    );

    function automatic int randBelow(input int limit);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % limit;
    endfunction

    // timestamp lands in the wanted bin with random bits below it
    function automatic histPkg::hit_t makeHit(input int pixel, input int bin);
        histPkg::hit_t h;
        int            ts;
        ts          = (bin << binShift) | randBelow(2 ** binShift);
        h.pixel     = pixel[histPkg::PIXEL_BITS-1:0];
        h.timestamp = ts[histPkg::TIME_BITS-1:0];
        return h;
    endfunction

    function automatic histPkg::hit_t randomHit(input int binLimit, input logic skipPixel2);
        int pixel;
        pixel = randBelow(numPixels);
        if (skipPixel2 && pixel == 2) begin
            pixel = 3;
        end
        return makeHit(pixel, randBelow(binLimit));
    endfunction

    function automatic histPkg::hit_t strayHit();
        return makeHit(1, numBins - 1);  // bin that no counted hit uses in the drop test
    endfunction

    function automatic void clearModel();
        int p;
        int b;
        for (p = 0; p < numPixels; p++) begin
            for (b = 0; b < numBins; b++) begin
                refHist[p][b] = 0;
            end
        end
        modelHits = 0;
        peakIdx   = 0;
    endfunction

    function automatic void countHit(input histPkg::hit_t h);
        int bin;
        bin = (h.timestamp >> binShift) % numBins;
        modelHits++;
        if (refHist[h.pixel][bin] < maxCount) begin
            refHist[h.pixel][bin]++;  // saturating count
        end
    endfunction

    // highest count wins and a tie keeps the lowest bin
    function automatic histPkg::peak_t expectedPeak(input int pix);
        histPkg::peak_t p;
        int             b;
        int             best;
        best    = 0;
        p.pixel = pix[histPkg::PIXEL_BITS-1:0];
        p.bin   = '0;
        p.count = '0;
        for (b = 0; b < numBins; b++) begin
            if (refHist[pix][b] > best) begin
                best    = refHist[pix][b];
                p.bin   = b[histPkg::BIN_BITS-1:0];
                p.count = best[histPkg::COUNT_BITS-1:0];
            end
        end
        return p;
    endfunction

    task automatic expectBit(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t %s: expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic checkQuiet();
        expectBit("busy", busy, 1'b0);
        expectBit("accepting", accepting, 1'b0);
        expectBit("peakValid", peakValid, 1'b0);
        expectBit("done", done, 1'b0);
    endtask

    task automatic reportTest(input int num, input string name, input int errBefore);
        testsRun++;
        if (errors == errBefore) begin
            $display("test %0d %s: ok, %0d hits counted", num, name, modelHits);
        end else begin
            testsFailed++;
            $display("test %0d %s: failed with %0d errors", num, name, errors - errBefore);
        end
    endtask

    // one frame from start through clear and hits until done
    task automatic runFrame(input int mode);
        int            n;
        int            gapLeft;
        int            runLeft;
        histPkg::hit_t runHit;
        clearModel();
        if (mode == modeDrop) begin
            repeat (10) begin  // strays while idle are never counted
                @(posedge clk);
                hitValid <= 1'b1;
                hit      <= strayHit();
            end
        end
        @(posedge clk);
        hitValid <= 1'b0;
        start    <= 1'b1;
        @(negedge clk);
        n = 0;
        while (!accepting && n < 2 * clearCycles) begin
            @(posedge clk);
            start    <= 1'b0;
            hitValid <= (mode == modeDrop) && (n < clearCycles - 4);
            hit      <= strayHit();
            @(negedge clk);
            n++;
            if (n == 1) begin
                expectBit("busy", busy, 1'b1);
            end
        end
        checks++;
        if (n != clearCycles + 1) begin
            errors++;
            $display("[ERROR] %0t accepting delay after start: expected %0d cycles, got %0d",
                     $time, clearCycles + 1, n);
        end
        n       = 0;
        gapLeft = 0;
        runLeft = 0;
        while (accepting && n < 5 * hitsPerFrame) begin
            @(posedge clk);
            start <= (mode == modeRestart) && (n == 50);  // ignored since the frame is busy
            case (mode)
                modeSparse, modeDrop: begin
                    if (gapLeft > 0) begin
                        hitValid <= 1'b0;
                        gapLeft--;
                    end else begin
                        hitValid <= 1'b1;
                        hit      <= randomHit((mode == modeDrop) ? numBins / 2 : numBins, 1'b0);
                        gapLeft  = 1 + randBelow(2);
                    end
                end
                modeDense, modeRestart: begin
                    if (runLeft == 0) begin  // new run of one bin
                        runHit  = randomHit(numBins, mode == modeRestart);
                        runLeft = 1 + randBelow(24);
                    end
                    hitValid <= 1'b1;
                    hit      <= makeHit(runHit.pixel, runHit.timestamp >> binShift);
                    runLeft--;
                end
                default: begin
                    hitValid <= (n % 3 != 2);  // two strobes then one gap
                    hit      <= makeHit(2, 9);
                end
            endcase
            @(negedge clk);
            n++;
        end
        checks++;
        if (accepting) begin
            errors++;
            $display("[ERROR] %0t accepting never fell after %0d cycles of hits", $time, n);
        end
        n = 0;
        while (!done && n < 4 * numBins * numPixels) begin
            @(posedge clk);
            start    <= (mode == modeRestart) && (n == 20);
            hitValid <= (mode == modeDrop);
            hit      <= strayHit();
            @(negedge clk);
            n++;
        end
        checks++;
        if (!done) begin
            errors++;
            $display("[ERROR] %0t done did not arrive within %0d cycles", $time, n);
        end
        @(posedge clk);
        start    <= 1'b0;
        hitValid <= 1'b0;
        @(negedge clk);
        expectBit("busy", busy, 1'b0);
    endtask

    // reference model sees exactly the hits the DUT samples
    always @(negedge clk) begin
        if (res === 1'b1 && hitValid === 1'b1 && accepting === 1'b1) begin
            countHit(hit);
        end
    end

    always @(negedge clk) begin : compare
        histPkg::peak_t expPeak;
        if (res === 1'b1 && peakValid === 1'b1) begin
            checks++;
            if (peakIdx >= numPixels) begin
                errors++;
                $display("[ERROR] %0t more than %0d peaks in one frame", $time, numPixels);
            end else begin
                expPeak = expectedPeak(peakIdx);
                if (peak !== expPeak) begin
                    errors++;
                    $display("[ERROR] %0t peak: expected %0d/%0d/%0d, got %0d/%0d/%0d",
                             $time, expPeak.pixel, expPeak.bin, expPeak.count,
                             peak.pixel, peak.bin, peak.count);
                end
                seenPeak[peakIdx] = peak;
            end
            peakIdx++;
        end
        if (res === 1'b1 && done === 1'b1) begin
            checks++;
            if (peakIdx != numPixels) begin
                errors++;
                $display("[ERROR] %0t peaks before done: expected %0d, got %0d",
                         $time, numPixels, peakIdx);
            end
            peakIdx = 0;
        end
    end

    initial begin : watchdog
        #(timeoutCycles * clkPeriod);
        $display("run timed out after %0d cycles without finishing", timeoutCycles);
        $display("** FAIL **");
        $finish;
    end

    initial begin : main
        int i;
        int errBefore;
        int totalErrors;
        res      = 1'b0;
        start    = 1'b0;
        hitValid = 1'b0;
        hit      = '0;
        clearModel();

        errBefore = errors;
        for (i = 0; i < resCycles; i++) begin
            @(negedge clk);
            checkQuiet();
        end
        @(posedge clk);
        res <= 1'b1;
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            checkQuiet();
        end
        reportTest(1, "reset state", errBefore);

        errBefore = errors;
        runFrame(modeSparse);
        reportTest(2, "sparse frame", errBefore);

        errBefore = errors;
        runFrame(modeDense);
        reportTest(3, "dense frame", errBefore);

        errBefore = errors;
        runFrame(modeSat);
        checks++;
        if (seenPeak[2].count !== hitsPerFrame || seenPeak[2].bin !== 4'd9) begin
            errors++;
            $display("[ERROR] %0t peak pixel 2: expected bin 9 count %0d, got bin %0d count %0d",
                     $time, hitsPerFrame, seenPeak[2].bin, seenPeak[2].count);
        end
        reportTest(4, "single bin frame", errBefore);

        errBefore = errors;
        runFrame(modeRestart);  // pixel 2 must read back empty
        reportTest(5, "frame restart", errBefore);

        errBefore = errors;
        runFrame(modeDrop);
        reportTest(6, "dropped hits", errBefore);

        totalErrors = errors + i_histTop.i_histAccumulator.i_accProperties.failCount;
        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 testsRun, testsFailed, checks, errors,
                 i_histTop.i_histAccumulator.i_accProperties.failCount);
        if (totalErrors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- tests/histAccumulator_properties.sv
`timescale 1ns/100ps

module histAccumulator_properties (
    input logic       clk,
    input logic       res,
    input logic [2:0] state,
    input logic       busy,
    input logic       binValid,
    input logic       scanStart,
    input logic       wEnable
);

    localparam logic [2:0] scanState = 3'd4;  // encoding of the scan state

    int failCount = 0;  // assertion failures so far

    // the RAM read port belongs either to the hits or to the scan
    assert property (@(posedge clk) disable iff (!res) state == scanState |-> !binValid)
        else begin
            failCount++;
            $error("hit reached the accumulator in the scan state");
        end

    assert property (@(posedge clk) disable iff (!res) scanStart |-> busy)
        else begin
            failCount++;
            $error("scanStart pulsed while not busy");
        end

    // RAM contents must survive between frames
    assert property (@(posedge clk) disable iff (!res) !busy |-> !wEnable)
        else begin
            failCount++;
            $error("RAM write while the accumulator is idle");
        end

endmodule

bind histAccumulator histAccumulator_properties i_accProperties (
    .clk       (clk),
    .res       (res),
    .state     (state),
    .busy      (busy),
    .binValid  (binValid),
    .scanStart (scanStart),
    .wEnable   (wEnable)
);

//--- tests/tbClock.sv
`timescale 1ns/100ps

module tbClock #(
    parameter realtime period = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(period / 2.0) clk = ~clk;  // free running, 50 % duty

endmodule

//--- rtl/histTop.sv
`timescale 1ns/100ps

module histTop #(
    parameter int binShift     = 6,
    parameter int hitsPerFrame = 200
) (
    input  logic           clk,
    input  logic           res,
    input  logic           start,
    input  logic           hitValid,
    input  histPkg::hit_t  hit,
    output logic           busy,
    output logic           accepting,
    output logic           peakValid,
    output histPkg::peak_t peak,
    output logic           done
);

    logic                           binValid;
    histPkg::binAddr_t              binAddr;
    logic                           scanStart;
    histPkg::binAddr_t              scanAddr;
    logic [histPkg::COUNT_BITS-1:0] scanCount;
    logic                           scanDone;

    assign done = scanDone;  // frame ends with the scan

    hitCapture #(
        .binShift (binShift)
    ) i_hitCapture (
        .clk       (clk),
        .res       (res),
        .hitValid  (hitValid),
        .hit       (hit),
        .accepting (accepting),
        .binValid  (binValid),
        .binAddr   (binAddr)
    );

    histAccumulator #(
        .hitsPerFrame (hitsPerFrame)
    ) i_histAccumulator (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .binValid  (binValid),
        .binAddr   (binAddr),
        .scanAddr  (scanAddr),
        .scanDone  (scanDone),
        .busy      (busy),
        .accepting (accepting),
        .scanStart (scanStart),
        .scanCount (scanCount)
    );

    peakFinder i_peakFinder (
        .clk       (clk),
        .res       (res),
        .scanStart (scanStart),
        .scanCount (scanCount),
        .scanAddr  (scanAddr),
        .peakValid (peakValid),
        .peak      (peak),
        .scanDone  (scanDone)
    );

endmodule

//--- rtl/peakFinder.sv
`timescale 1ns/100ps

module peakFinder (
    input  logic                           clk,
    input  logic                           res,
    input  logic                           scanStart,
    input  logic [histPkg::COUNT_BITS-1:0] scanCount,
    output histPkg::binAddr_t              scanAddr,
    output logic                           peakValid,
    output histPkg::peak_t                 peak,
    output logic                           scanDone
);

    logic                           active;   // addresses being issued
    logic                           rdValid;  // scanCount belongs to rdAddr
    histPkg::binAddr_t              rdAddr;
    logic                           rdLast;
    logic [histPkg::COUNT_BITS-1:0] maxCount;
    logic [histPkg::BIN_BITS-1:0]   maxBin;
    logic                           take;
    logic [histPkg::COUNT_BITS-1:0] bestCount;
    logic [histPkg::BIN_BITS-1:0]   bestBin;

    assign rdLast = (rdAddr.bin == '1);

    // strictly greater, so a tie keeps the lower bin
    assign take      = (scanCount > maxCount);
    assign bestCount = take ? scanCount : maxCount;
    assign bestBin   = take ? rdAddr.bin : maxBin;

    // address walker, pixel 0 to 3, bins 0 to 15
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            active   <= 1'b0;
            scanAddr <= '0;
            rdValid  <= 1'b0;
        end else begin
            rdValid <= active;
            if (scanStart) begin
                active   <= 1'b1;
                scanAddr <= '0;
            end else if (active) begin
                scanAddr <= histPkg::binAddr_t'(scanAddr + 1'b1);
                if (scanAddr == '1) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // address of the count coming back from the RAM
    always_ff @(posedge clk) begin
        rdAddr <= scanAddr;
    end

    // running maximum, cleared at each pixel boundary
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            maxCount  <= '0;
            maxBin    <= '0;
            peakValid <= 1'b0;
            scanDone  <= 1'b0;
        end else begin
            peakValid <= rdValid & rdLast;
            scanDone  <= peakValid & (peak.pixel == '1);  // after the last pixel
            if (rdValid) begin
                if (rdLast) begin
                    maxCount <= '0;
                    maxBin   <= '0;
                end else begin
                    maxCount <= bestCount;
                    maxBin   <= bestBin;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdValid && rdLast) begin
            peak.pixel <= rdAddr.pixel;
            peak.bin   <= bestBin;
            peak.count <= bestCount;
        end
    end

endmodule

//--- rtl/histAccumulator.sv
`timescale 1ns/100ps

module histAccumulator #(
    parameter int hitsPerFrame = 200
) (
    input  logic                           clk,
    input  logic                           res,
    input  logic                           start,
    input  logic                           binValid,
    input  histPkg::binAddr_t              binAddr,
    input  histPkg::binAddr_t              scanAddr,
    input  logic                           scanDone,
    output logic                           busy,
    output logic                           accepting,
    output logic                           scanStart,
    output logic [histPkg::COUNT_BITS-1:0] scanCount
);

    localparam int CNT_BITS = $clog2(hitsPerFrame + 1);

    localparam logic [2:0] IDLE  = 3'd0;
    localparam logic [2:0] CLEAR = 3'd1;
    localparam logic [2:0] ACCUM = 3'd2;
    localparam logic [2:0] DRAIN = 3'd3;
    localparam logic [2:0] SCAN  = 3'd4;

    logic [2:0]                     state;
    histPkg::binAddr_t              clearAddr;
    logic [CNT_BITS-1:0]            hitCount;
    logic                           issue;
    logic                           incValid;  // write stage of the RMW
    histPkg::binAddr_t              incAddr;
    logic                           fwdValid;
    logic [histPkg::COUNT_BITS-1:0] fwdData;
    logic [histPkg::COUNT_BITS-1:0] base;
    logic [histPkg::COUNT_BITS-1:0] incCount;
    logic                           wEnable;
    histPkg::binAddr_t              waddr;
    histPkg::binAddr_t              raddr;
    logic [histPkg::COUNT_BITS-1:0] wdata;
    logic [histPkg::COUNT_BITS-1:0] rdata;

    assign busy      = (state != IDLE);
    assign accepting = (state == ACCUM);

    // a straggler captured in the last accumulate cycle still gets counted in drain
    assign issue = binValid & ((state == ACCUM) | (state == DRAIN));

    // back-to-back hit on the same bin, RAM data is one write behind
    assign base     = fwdValid ? fwdData : rdata;
    assign incCount = (base == '1) ? base : base + 1'b1;  // saturate

    // RAM port muxing
    assign wEnable   = (state == CLEAR) | incValid;
    assign waddr     = (state == CLEAR) ? clearAddr : incAddr;
    assign wdata     = (state == CLEAR) ? '0 : incCount;
    assign raddr     = (state == SCAN) ? scanAddr : binAddr;
    assign scanCount = rdata;

    histRam i_histRam (
        .clk     (clk),
        .wEnable (wEnable),
        .waddr   (waddr),
        .raddr   (raddr),
        .wdata   (wdata),
        .rdata   (rdata)
    );

    // frame FSM
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= IDLE;
            clearAddr <= '0;
            hitCount  <= '0;
            scanStart <= 1'b0;
        end else begin
            scanStart <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state     <= CLEAR;
                        clearAddr <= '0;
                    end
                end
                CLEAR: begin  // one zero word per cycle
                    clearAddr <= histPkg::binAddr_t'(clearAddr + 1'b1);
                    if (clearAddr == '1) begin
                        state    <= ACCUM;
                        hitCount <= '0;
                    end
                end
                ACCUM: begin
                    if (binValid) begin
                        hitCount <= hitCount + 1'b1;
                        if (hitCount == CNT_BITS'(hitsPerFrame - 1)) begin
                            state <= DRAIN;
                        end
                    end
                end
                DRAIN: begin
                    // no read left to issue, the final write is in this cycle
                    if (!binValid) begin
                        state     <= SCAN;
                        scanStart <= 1'b1;
                    end
                end
                SCAN: begin
                    if (scanDone) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // read-modify-write pipeline control
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            incValid <= 1'b0;
            fwdValid <= 1'b0;
        end else begin
            incValid <= issue;
            fwdValid <= issue & incValid & (binAddr == incAddr);
        end
    end

    always_ff @(posedge clk) begin
        incAddr <= binAddr;
        fwdData <= wdata;  // value just written, for the next hit
    end

endmodule

//--- rtl/histRam.sv
`timescale 1ns/100ps

module histRam (
    input  logic                           clk,
    input  logic                           wEnable,
    input  histPkg::binAddr_t              waddr,
    input  histPkg::binAddr_t              raddr,
    input  logic [histPkg::COUNT_BITS-1:0] wdata,
    output logic [histPkg::COUNT_BITS-1:0] rdata
);

    localparam int DEPTH = 2 ** histPkg::ADDR_BITS;

    logic [histPkg::COUNT_BITS-1:0] mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wEnable) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, returns the old word on a same-address write
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

//--- rtl/hitCapture.sv
`timescale 1ns/100ps

module hitCapture #(
    parameter int binShift = 6  // low timestamp bits dropped
) (
    input  logic              clk,
    input  logic              res,
    input  logic              hitValid,
    input  histPkg::hit_t     hit,
    input  logic              accepting,
    output logic              binValid,
    output histPkg::binAddr_t binAddr
);

    logic                          take;
    logic [histPkg::BIN_BITS-1:0]  binField;
    histPkg::binAddr_t             nextAddr;

    // only hits seen while the accumulator listens
    assign take = hitValid & accepting;

    // coarse time bin, a window of the timestamp
    assign binField = hit.timestamp[binShift +: histPkg::BIN_BITS];

    always_comb begin
        nextAddr.pixel = hit.pixel;
        nextAddr.bin   = binField;
    end

    // strobe, one cycle behind hitValid
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binValid <= 1'b0;
        end else begin
            binValid <= take;
        end
    end

    // address register, loaded only on an accepted hit
    always_ff @(posedge clk) begin
        if (take) begin
            binAddr <= nextAddr;
        end
    end

endmodule

//--- rtl/histPkg.sv
package histPkg;

    localparam int PIXEL_BITS = 2;  // four pixels
    localparam int BIN_BITS   = 4;  // 16 bins per pixel
    localparam int TIME_BITS  = 10;
    localparam int COUNT_BITS = 8;  // saturates at 255
    localparam int ADDR_BITS  = PIXEL_BITS + BIN_BITS;

    // one photon hit as it leaves the TDC
    typedef struct packed {
        logic [PIXEL_BITS-1:0] pixel;
        logic [TIME_BITS-1:0]  timestamp;
    } hit_t;

    // histogram RAM address, pixel in the upper bits
    typedef struct packed {
        logic [PIXEL_BITS-1:0] pixel;
        logic [BIN_BITS-1:0]   bin;
    } binAddr_t;

    // per-pixel result of the scan
    typedef struct packed {
        logic [PIXEL_BITS-1:0] pixel;
        logic [BIN_BITS-1:0]   bin;
        logic [COUNT_BITS-1:0] count;
    } peak_t;

endpackage
